// ==== spart_baud_gen.sv ====
`default_nettype none

module spart_baud_gen #(
	parameter spart_serial_pkg::divisor_t DIVISOR_RESET = 16'd650
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       div_wr,
	input  spart_serial_pkg::divisor_t div_value,
	output logic                       tick
);
	import spart_serial_pkg::*;

	// Current divisor
	divisor_t divisor;
	// Clocks left until the next tick
	divisor_t count;

	// Divisor register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			divisor <= DIVISOR_RESET;
		else if (div_wr)
			divisor <= div_value;
	end

	//////////////////////////////////////////////////////////////////////
	// 16x sample tick
	//////////////////////////////////////////////////////////////////////

	// Down-counter, reloads at zero
	// A new divisor restarts the count right away
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			count <= DIVISOR_RESET;
		else if (div_wr)
			count <= div_value;
		else if (count == '0)
			count <= divisor;
		else
			count <= count - 1'b1;
	end

	// One clock wide, every divisor + 1 clocks
	assign tick = (count == '0);

endmodule

`default_nettype wire

// ==== spart_bus_decode.sv ====
`default_nettype none

module spart_bus_decode (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       io_valid_data,
	input  logic                       io_rw_data,
	input  spart_bus_pkg::bus_addr_t   mem_addr,
	input  spart_bus_pkg::bus_word_t   io_wr_data,
	input  logic                       tbr,
	input  logic                       rda,
	output logic                       io_ready_data,
	output logic                       data_wr,
	output logic                       div_wr,
	output logic                       rd_go,
	output spart_bus_pkg::rd_sel_t     rd_sel,
	output spart_serial_pkg::byte_t    tx_byte,
	output spart_serial_pkg::divisor_t div_value
);
	import spart_bus_pkg::*;
	import spart_serial_pkg::*;

	logic hit_data;
	logic hit_status;
	logic hit_div;
	logic allow;
	logic go;
	// Access already served, wait for valid to drop
	logic busy;
	// One-clock ready pulse
	logic done;

	//////////////////////////////////////////////////////////////////////
	// Address compare
	//////////////////////////////////////////////////////////////////////

	assign hit_data   = (mem_addr == ADDR_DATA);
	assign hit_status = (mem_addr == ADDR_STATUS);
	assign hit_div    = (mem_addr == ADDR_DIVISOR);

	// Divisor is write only, so its reads fall to zero too
	always_comb begin
		rd_sel = '0;
		if (hit_data)
			rd_sel[SEL_DATA] = 1'b1;
		else if (hit_status)
			rd_sel[SEL_STATUS] = 1'b1;
		else
			rd_sel[SEL_ZERO] = 1'b1;
	end

	// Data writes wait for an empty transmitter, data reads for a byte
	assign allow = hit_data ? (io_rw_data ? tbr : rda) : 1'b1;

	// Accept once per valid
	assign go = io_valid_data & ~busy & allow;

	//////////////////////////////////////////////////////////////////////
	// Strobes to execute and result stages
	//////////////////////////////////////////////////////////////////////

	assign data_wr = go & io_rw_data & hit_data;
	assign div_wr  = go & io_rw_data & hit_div;
	assign rd_go   = go & ~io_rw_data;

	// Low bits of the write word
	assign tx_byte   = io_wr_data[BYTE_W-1:0];
	assign div_value = io_wr_data[DIV_W-1:0];

	// Handshake state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= go;
			if (go)
				busy <= 1'b1;
			else if (!io_valid_data)
				busy <= 1'b0;
		end
	end

	assign io_ready_data = done;

endmodule

`default_nettype wire

// ==== spart_bus_pkg.sv ====
`default_nettype none

package spart_bus_pkg;

	//////////////////////////////////////////////////////////////////////
	// Cache-side I/O bus
	//////////////////////////////////////////////////////////////////////

	localparam int BUS_ADDR_W = 28;
	localparam int BUS_WORD_W = 32;

	// One word of I/O address space
	typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
	// Read and write data, one word
	typedef logic [BUS_WORD_W-1:0] bus_word_t;

	// Register map
	// Write sends a byte, read returns the received byte
	localparam bus_addr_t ADDR_DATA    = 28'h800_0000;
	localparam bus_addr_t ADDR_STATUS  = 28'h800_0001;
	localparam bus_addr_t ADDR_DIVISOR = 28'h800_0002;

	// Status word layout, all other bits read as zero
	localparam int STAT_RDA_BIT = 0;
	localparam int STAT_TBR_BIT = 1;

	//////////////////////////////////////////////////////////////////////
	// Read select, one-hot
	//////////////////////////////////////////////////////////////////////

	localparam int RD_SEL_W = 3;

	typedef logic [RD_SEL_W-1:0] rd_sel_t;

	localparam int SEL_DATA   = 0;
	localparam int SEL_STATUS = 1;
	// Divisor and unmapped reads land here
	localparam int SEL_ZERO   = 2;

endpackage

`default_nettype wire

// ==== spart_result.sv ====
`default_nettype none

module spart_result (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     rd_go,
	input  spart_bus_pkg::rd_sel_t   rd_sel,
	input  spart_serial_pkg::byte_t  rx_byte,
	input  logic                     rda,
	input  logic                     tbr,
	output spart_bus_pkg::bus_word_t io_rd_data,
	output logic                     rx_take
);
	import spart_bus_pkg::*;

	bus_word_t status_word;
	bus_word_t rd_word;

	//////////////////////////////////////////////////////////////////////
	// Read word build
	//////////////////////////////////////////////////////////////////////

	// Only the two flags, rest stays zero
	always_comb begin
		status_word               = '0;
		status_word[STAT_RDA_BIT] = rda;
		status_word[STAT_TBR_BIT] = tbr;
	end

	// One-hot pick, zero select gives zero
	always_comb begin
		rd_word = '0;
		if (rd_sel[SEL_DATA])
			rd_word = bus_word_t'(rx_byte);
		else if (rd_sel[SEL_STATUS])
			rd_word = status_word;
		else if (rd_sel[SEL_ZERO])
			rd_word = '0;
	end

	// Held until the next read, lines up with ready
	always_ff @(posedge clk) begin
		if (rd_go)
			io_rd_data <= rd_word;
	end

	// Data read consumed, tell the receiver
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rx_take <= 1'b0;
		else
			rx_take <= rd_go & rd_sel[SEL_DATA];
	end

endmodule

`default_nettype wire

// ==== spart_rx.sv ====
`default_nettype none

module spart_rx (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    tick,
	input  logic                    rxd,
	input  logic                    rx_take,
	output spart_serial_pkg::byte_t rx_byte,
	output logic                    rda
);
	import spart_serial_pkg::*;

	// Two-flop synchroniser
	logic        rxd_meta;
	logic        rxd_sync;
	// Line level at the previous tick, for edge find
	logic        rxd_last;
	rx_state_t   state;
	sample_cnt_t sample_cnt;
	bit_idx_t    bit_idx;
	byte_t       shift;
	// Mid-bit data sample
	logic        data_sample;
	// Stop bit read as 1
	logic        frame_good;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	assign data_sample = tick && (state == RX_DATA) && (sample_cnt == LAST_SAMPLE);
	assign frame_good  = tick && (state == RX_STOP) && (sample_cnt == LAST_SAMPLE) && rxd_sync;

	//////////////////////////////////////////////////////////////////////
	// Receive FSM, advances on the 16x tick
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= RX_IDLE;
			sample_cnt <= '0;
			bit_idx    <= '0;
			rxd_last   <= 1'b1;
		end else if (tick) begin
			rxd_last <= rxd_sync;
			case (state)
				RX_IDLE: begin
					// High to low marks a start bit
					if (rxd_last && !rxd_sync) begin
						state      <= RX_START;
						sample_cnt <= '0;
					end
				end
				RX_START: begin
					sample_cnt <= sample_cnt + 1'b1;
					if (sample_cnt == MID_SAMPLE) begin
						// Glitch if the line is back high by mid-bit
						if (!rxd_sync) begin
							state      <= RX_DATA;
							sample_cnt <= '0;
							bit_idx    <= '0;
						end else begin
							state <= RX_IDLE;
						end
					end
				end
				RX_DATA: begin
					sample_cnt <= sample_cnt + 1'b1;
					if (sample_cnt == LAST_SAMPLE) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == LAST_DATA_IDX)
							state <= RX_STOP;
					end
				end
				RX_STOP: begin
					sample_cnt <= sample_cnt + 1'b1;
					// Bad stop bit just drops the frame
					if (sample_cnt == LAST_SAMPLE)
						state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Data arrives LSB first
	always_ff @(posedge clk) begin
		if (data_sample)
			shift <= {rxd_sync, shift[BYTE_W-1:1]};
		if (frame_good)
			rx_byte <= shift;
	end

	// New byte wins over a read in the same clock
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rda <= 1'b0;
		else if (frame_good)
			rda <= 1'b1;
		else if (rx_take)
			rda <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== spart_serial_pkg.sv ====
`default_nettype none

package spart_serial_pkg;

	localparam int BYTE_W = 8;
	localparam int DIV_W  = 16;

	// One data byte on the line
	typedef logic [BYTE_W-1:0] byte_t;
	// Tick period is divisor + 1 clocks
	typedef logic [DIV_W-1:0]  divisor_t;
	// 16x ticks inside one bit, wraps naturally
	typedef logic [3:0]        sample_cnt_t;
	// Bit position inside a frame
	typedef logic [3:0]        bit_idx_t;

	// 8N1 frame, start + 8 data + stop
	localparam int FRAME_BITS = 10;

	// Tick counts inside one bit
	localparam sample_cnt_t MID_SAMPLE  = 4'd7;
	localparam sample_cnt_t LAST_SAMPLE = 4'd15;

	// Bit indices
	localparam bit_idx_t LAST_DATA_IDX = 4'd7;
	localparam bit_idx_t STOP_IDX      = 4'd9;

	// Receiver FSM
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

endpackage

`default_nettype wire

// ==== spart_top.sv ====
`default_nettype none

module spart_top_level #(
	parameter spart_serial_pkg::divisor_t DIVISOR_RESET = 16'd650
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     rxd,
	input  logic                     io_rw_data,
	input  logic                     io_valid_data,
	input  spart_bus_pkg::bus_addr_t mem_addr,
	input  spart_bus_pkg::bus_word_t io_wr_data,
	output logic                     txd,
	output logic                     io_ready_data,
	output spart_bus_pkg::bus_word_t io_rd_data
);
	import spart_bus_pkg::*;
	import spart_serial_pkg::*;

	// Decode strobes
	logic     data_wr;
	logic     div_wr;
	logic     rd_go;
	rd_sel_t  rd_sel;
	byte_t    tx_byte;
	divisor_t div_value;

	// Execute side flags and data
	logic     tick;
	logic     tbr;
	logic     rda;
	byte_t    rx_byte;
	logic     rx_take;

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////

	spart_bus_decode u_decode (
		.clk           (clk),
		.rst_n         (rst_n),
		.io_valid_data (io_valid_data),
		.io_rw_data    (io_rw_data),
		.mem_addr      (mem_addr),
		.io_wr_data    (io_wr_data),
		.tbr           (tbr),
		.rda           (rda),
		.io_ready_data (io_ready_data),
		.data_wr       (data_wr),
		.div_wr        (div_wr),
		.rd_go         (rd_go),
		.rd_sel        (rd_sel),
		.tx_byte       (tx_byte),
		.div_value     (div_value)
	);

	//////////////////////////////////////////////////////////////////////
	// Execute
	//////////////////////////////////////////////////////////////////////

	spart_baud_gen #(
		.DIVISOR_RESET (DIVISOR_RESET)
	) u_baud (
		.clk       (clk),
		.rst_n     (rst_n),
		.div_wr    (div_wr),
		.div_value (div_value),
		.tick      (tick)
	);

	spart_tx u_tx (
		.clk     (clk),
		.rst_n   (rst_n),
		.tick    (tick),
		.data_wr (data_wr),
		.tx_byte (tx_byte),
		.txd     (txd),
		.tbr     (tbr)
	);

	spart_rx u_rx (
		.clk     (clk),
		.rst_n   (rst_n),
		.tick    (tick),
		.rxd     (rxd),
		.rx_take (rx_take),
		.rx_byte (rx_byte),
		.rda     (rda)
	);

	// Result
	spart_result u_result (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_go      (rd_go),
		.rd_sel     (rd_sel),
		.rx_byte    (rx_byte),
		.rda        (rda),
		.tbr        (tbr),
		.io_rd_data (io_rd_data),
		.rx_take    (rx_take)
	);

endmodule

`default_nettype wire

// ==== spart_tx.sv ====
`default_nettype none

module spart_tx (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    tick,
	input  logic                    data_wr,
	input  spart_serial_pkg::byte_t tx_byte,
	output logic                    txd,
	output logic                    tbr
);
	import spart_serial_pkg::*;

	// Frame loaded and not yet finished
	logic                  busy;
	// Start bit already on the line
	logic                  started;
	// Shift register, bit 0 goes out next
	logic [FRAME_BITS-1:0] frame;
	sample_cnt_t           sample_cnt;
	bit_idx_t              bit_idx;
	// Registered line driver
	logic                  txd_q;

	//////////////////////////////////////////////////////////////////////
	// Shift engine
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			started    <= 1'b0;
			frame      <= '1;
			sample_cnt <= '0;
			bit_idx    <= '0;
			txd_q      <= 1'b1;
		end else if (data_wr && !busy) begin
			// Stop, data LSB first, start from top to bottom
			busy    <= 1'b1;
			started <= 1'b0;
			frame   <= {1'b1, tx_byte, 1'b0};
		end else if (busy && tick) begin
			if (!started) begin
				// Line drops on a tick boundary
				started    <= 1'b1;
				txd_q      <= frame[0];
				sample_cnt <= '0;
				bit_idx    <= '0;
			end else if (sample_cnt == LAST_SAMPLE) begin
				sample_cnt <= '0;
				if (bit_idx == STOP_IDX) begin
					// Stop bit served its 16 ticks
					busy    <= 1'b0;
					started <= 1'b0;
					txd_q   <= 1'b1;
				end else begin
					frame   <= {1'b1, frame[FRAME_BITS-1:1]};
					txd_q   <= frame[1];
					bit_idx <= bit_idx + 1'b1;
				end
			end else begin
				sample_cnt <= sample_cnt + 1'b1;
			end
		end
	end

	assign txd = txd_q;
	// Buffer free whenever no frame is pending
	assign tbr = ~busy;

endmodule

`default_nettype wire

// ==== tb.f ====
spart_bus_pkg.sv
spart_serial_pkg.sv
spart_bus_decode.sv
spart_baud_gen.sv
spart_tx.sv
spart_rx.sv
spart_result.sv
spart_top.sv
tb_spart_top.sv

// ==== tb_spart_top.sv ====
`default_nettype none

module tb_spart_top;
	timeunit 1ns;
	timeprecision 1ps;

	import spart_bus_pkg::*;
	import spart_serial_pkg::*;

	localparam divisor_t TB_DIVISOR = 16'd3;
	localparam int MAX_DIV = 9;
	// Loopback bytes over all tests
	localparam int NUM_BYTES = 20 + 1 + 2 + 5 + 1;
	localparam int FRAME_TICKS = 10 * 16;
	localparam int TIMEOUT_CYCLES = NUM_BYTES * FRAME_TICKS * (MAX_DIV + 1) * 2 + 2000;
	// One access may wait out a full frame in flight plus reception
	localparam int ACCESS_LIMIT = 2 * FRAME_TICKS * (MAX_DIV + 1) + 100;

	logic      clk;
	logic      rst_n;
	logic      io_valid_data;
	logic      io_rw_data;
	bus_addr_t mem_addr;
	bus_word_t io_wr_data;
	logic      io_ready_data;
	bus_word_t io_rd_data;
	// Looped back into rxd
	logic      txd;

	int        seed = 280;
	int        cycles = 0;
	int        n_checks = 0;
	int        n_errors = 0;
	int        last_checks = 0;
	int        last_errors = 0;
	// Reference model
	byte_t     model_q[$];
	int        model_div = TB_DIVISOR;

	spart_top_level #(
		.DIVISOR_RESET (TB_DIVISOR)
	) UUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.rxd           (txd),
		.io_rw_data    (io_rw_data),
		.io_valid_data (io_valid_data),
		.mem_addr      (mem_addr),
		.io_wr_data    (io_wr_data),
		.txd           (txd),
		.io_ready_data (io_ready_data),
		.io_rd_data    (io_rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Run limit, counts every rising edge
	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the tests did not finish", cycles);
		$display("Checks failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Checks and reporting
	//////////////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
		n_checks++;
		assert (act === exp)
		else begin
			n_errors++;
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_true(input logic ok, input string what);
		n_checks++;
		assert (ok)
		else begin
			n_errors++;
			$display("%s (at %0t)", what, $time);
		end
	endtask

	task automatic finish_test(input string name);
		$display("Test %s done: %0d checks, %0d errors", name,
			n_checks - last_checks, n_errors - last_errors);
		last_checks = n_checks;
		last_errors = n_errors;
	endtask

	// Status rule, two flags and zeros elsewhere
	function automatic bus_word_t expected_status(input logic rda_exp, input logic tbr_exp);
		bus_word_t w;
		w = '0;
		w[STAT_RDA_BIT] = rda_exp;
		w[STAT_TBR_BIT] = tbr_exp;
		return w;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Bus driver, called just after a falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic write_reg(input bus_addr_t addr, input bus_word_t data,
			output int ready_cycle, output logic seen);
		int n;
		n = 0;
		seen = 1'b0;
		io_valid_data = 1'b1;
		io_rw_data = 1'b1;
		mem_addr = addr;
		io_wr_data = data;
		while (!seen && n < ACCESS_LIMIT) begin
			@(negedge clk);
			n++;
			seen = io_ready_data;
		end
		ready_cycle = cycles;
		io_valid_data = 1'b0;
		// Valid stays low for one edge between accesses
		@(negedge clk);
	endtask

	task automatic read_reg(input bus_addr_t addr, input int limit,
			output bus_word_t data, output logic seen);
		int n;
		n = 0;
		seen = 1'b0;
		data = '0;
		io_valid_data = 1'b1;
		io_rw_data = 1'b0;
		mem_addr = addr;
		while (!seen && n < limit) begin
			@(negedge clk);
			n++;
			seen = io_ready_data;
			if (seen)
				data = io_rd_data;
		end
		io_valid_data = 1'b0;
		@(negedge clk);
	endtask

	task automatic read_expect(input bus_addr_t addr, input bus_word_t exp, input string name);
		bus_word_t data;
		logic seen;
		read_reg(addr, ACCESS_LIMIT, data, seen);
		check_true(seen, $sformatf("Read of address %h never completed", addr));
		if (seen)
			check_word(name, exp, data);
	endtask

	// Write one byte to the data register and log it in the model
	task automatic send_byte(input byte_t b, output int ready_cycle);
		logic seen;
		write_reg(ADDR_DATA, bus_word_t'(b), ready_cycle, seen);
		check_true(seen, "Write to the data register never completed");
		model_q.push_back(b);
	endtask

	// Data read against the model queue head
	task automatic receive_byte();
		read_expect(ADDR_DATA, bus_word_t'(model_q.pop_front()), "io_rd_data");
	endtask

	task automatic loop_byte(input byte_t b);
		int rc;
		send_byte(b, rc);
		receive_byte();
	endtask

	// Poll status until the transmitter is free again
	task automatic wait_tx_idle();
		bus_word_t data;
		logic seen;
		int start;
		start = cycles;
		data = '0;
		while (!data[STAT_TBR_BIT] && cycles - start < ACCESS_LIMIT)
			read_reg(ADDR_STATUS, ACCESS_LIMIT, data, seen);
		check_true(data[STAT_TBR_BIT], "Transmitter never went idle");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		bus_word_t data;
		bus_addr_t addr;
		logic      seen;
		byte_t     b;
		int        r1;
		int        r2;
		int        k;

		io_valid_data = 1'b0;
		io_rw_data = 1'b0;
		mem_addr = '0;
		io_wr_data = '0;
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// 1. Reset state
		read_expect(ADDR_STATUS, expected_status(1'b0, 1'b1), "status");
		check_word("txd", 32'd1, bus_word_t'(txd));
		read_reg(ADDR_DATA, 300, data, seen);
		check_true(!seen, "Data read completed with nothing received");
		finish_test("reset_state");

		// 2. Loopback of random bytes
		repeat (20) begin
			b = $random(seed);
			loop_byte(b);
		end
		finish_test("loopback");

		// 3. Flags around one frame
		b = $random(seed);
		send_byte(b, r1);
		read_expect(ADDR_STATUS, expected_status(1'b0, 1'b0), "status");
		wait_tx_idle();
		// Byte landed before the stop bit ended
		read_expect(ADDR_STATUS, expected_status(1'b1, 1'b1), "status");
		receive_byte();
		read_expect(ADDR_STATUS, expected_status(1'b0, 1'b1), "status");
		finish_test("status_flags");

		// 4. Second write held off by a busy transmitter
		b = $random(seed);
		send_byte(b, r1);
		b = $random(seed);
		send_byte(b, r2);
		check_true(r2 - r1 >= FRAME_TICKS * (model_div + 1),
			"Second data write completed while the transmitter was busy");
		receive_byte();
		receive_byte();
		finish_test("back_pressure");

		// 5. New baud rate, then loopback again
		wait_tx_idle();
		model_div = 2 + ($unsigned($random(seed)) % 8);
		write_reg(ADDR_DIVISOR, bus_word_t'(model_div), r1, seen);
		check_true(seen, "Write to the divisor register never completed");
		for (k = 0; k < 5; k++) begin
			b = $random(seed);
			send_byte(b, r2);
			// From the second byte on, each write waits one frame at the new rate
			if (k > 0)
				check_true(r2 - r1 >= FRAME_TICKS * (model_div + 1) &&
					r2 - r1 <= (FRAME_TICKS + 1) * (model_div + 1) + 4,
					$sformatf("Writes %0d cycles apart do not fit divisor %0d",
						r2 - r1, model_div));
			r1 = r2;
			receive_byte();
		end
		finish_test("divisor_change");

		// 6. Address outside the register map
		addr = $random(seed);
		while (addr >= ADDR_DATA && addr <= ADDR_DIVISOR)
			addr = $random(seed);
		read_expect(addr, '0, "io_rd_data");
		wait_tx_idle();
		write_reg(addr, $random(seed), r1, seen);
		check_true(seen, $sformatf("Write to address %h never completed", addr));
		read_expect(ADDR_STATUS, expected_status(1'b0, 1'b1), "status");
		b = $random(seed);
		loop_byte(b);
		finish_test("unmapped");

		$display("Done: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
